// ==== source/alut_pkg.sv ====
// shared ALUT definitions
// table entry and table request structs, config and status bundles
// command and age checker state encodings, APB register offsets

package alut_pkg;

   localparam int unsigned req_addr_w = 8;   // request address field, fits addr_w up to 8

   // one table entry, 83 bits
   typedef struct packed {
      logic        valid;
      logic [31:0] last_accessed;            // curr_time when learned
      logic [1:0]  port;
      logic [47:0] mac;
   } alut_entry_t;

   // table request, one per requester
   typedef struct packed {
      logic                  req;
      logic                  write;           // 1 write, 0 read
      logic [req_addr_w-1:0] addr;
      alut_entry_t           wdata;
   } mem_req_t;

   typedef enum logic [1:0] {
      cmd_none       = 2'd0,
      cmd_rsvd       = 2'd1,
      cmd_inval_aged = 2'd2,
      cmd_inval_all  = 2'd3
   } age_cmd_e;

   typedef enum logic [2:0] {
      st_idle      = 3'd0,
      st_aged_rd   = 3'd1,
      st_age_chk   = 3'd2,
      st_aged_wr   = 3'd3,
      st_inval_all = 3'd4
   } age_state_e;

   // registers -> age checker
   typedef struct packed {
      logic [7:0]  div_clk;
      logic [31:0] best_bfr_age;
   } alut_cfg_t;

   // age checker -> registers
   typedef struct packed {
      logic        age_check_active;
      logic        inval_in_prog;
      logic [47:0] lst_inv_mac;
      logic [1:0]  lst_inv_port;
      logic [31:0] curr_time;
   } alut_status_t;

   // --------------------
   // APB byte offsets
   localparam logic [7:0] reg_cmd    = 8'h00;
   localparam logic [7:0] reg_div    = 8'h04;
   localparam logic [7:0] reg_age    = 8'h08;
   localparam logic [7:0] reg_status = 8'h0C;
   localparam logic [7:0] reg_time   = 8'h10;
   localparam logic [7:0] reg_inv_lo = 8'h14;
   localparam logic [7:0] reg_inv_hi = 8'h18;
   localparam logic [7:0] reg_mac_lo = 8'h1C;
   localparam logic [7:0] reg_mac_hi = 8'h20;
   localparam logic [7:0] reg_learn  = 8'h24;

endpackage

// ==== source/alut_apb_regs.sv ====
// APB register block of the ALUT
// config, command pulse, learn MAC/port and learn index registers
// learn write and entry read requests to the table, with pready stall
// read mux for status, time and last invalidated entry

module alut_apb_regs
(
   input  logic                   pclk26,
   input  logic                   n_p_reset26,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [7:0]             paddr,
   input  logic [31:0]            pwdata,
   input  logic                   learn_gnt,
   input  alut_pkg::alut_entry_t  rdata,
   input  alut_pkg::alut_status_t status,
   output logic [31:0]            prdata,
   output logic                   pready,
   output alut_pkg::alut_cfg_t    cfg,
   output alut_pkg::age_cmd_e     cmd,
   output alut_pkg::mem_req_t     learn_req
);

   import alut_pkg::*;

   logic                  acc;         // access phase
   logic                  is_learn;    // access targets reg_learn
   logic                  reg_wr;      // plain register write, completes at once
   logic                  learn_wr;
   logic                  learn_rd;
   logic                  rd_wait;     // entry read granted, rdata due this cycle
   logic [7:0]            div_q;
   logic [31:0]           age_q;
   logic [47:0]           lrn_mac;
   logic [1:0]            lrn_port;
   logic [req_addr_w-1:0] lrn_idx;     // index of last learn write

   assign acc      = psel & penable;
   assign is_learn = (paddr == reg_learn);
   assign reg_wr   = acc & pwrite & ~is_learn;
   assign learn_wr = acc & pwrite & is_learn;
   assign learn_rd = acc & ~pwrite & is_learn;

   // --------------------
   // config and learn data registers
   always_ff @(posedge pclk26 or negedge n_p_reset26)
   begin
      if (!n_p_reset26)
      begin
         div_q    <= 8'd0;
         age_q    <= 32'd0;
         lrn_mac  <= 48'd0;
         lrn_port <= 2'd0;
         lrn_idx  <= '0;
         cmd      <= cmd_none;
      end
      else
      begin
         cmd <= cmd_none;                                // pulse, one cycle only
         if (reg_wr)
         begin
            case (paddr)
               reg_cmd    : cmd <= age_cmd_e'(pwdata[1:0]);
               reg_div    : div_q <= pwdata[7:0];
               reg_age    : age_q <= pwdata;
               reg_mac_lo : lrn_mac[31:0] <= pwdata;
               reg_mac_hi :
               begin
                  lrn_mac[47:32] <= pwdata[15:0];
                  lrn_port       <= pwdata[17:16];
               end
               default    : ;                            // read-only or unmapped
            endcase
         end
         if (learn_wr && learn_gnt)
            lrn_idx <= pwdata[req_addr_w-1:0];           // kept for entry reads
      end
   end

   assign cfg.div_clk      = div_q;
   assign cfg.best_bfr_age = age_q;

   // --------------------
   // learn port, held until the table grants
   always_comb
   begin
      learn_req.req                 = learn_wr | (learn_rd & ~rd_wait);
      learn_req.write               = pwrite;
      learn_req.addr                = pwrite ? pwdata[req_addr_w-1:0] : lrn_idx;
      learn_req.wdata.valid         = 1'b1;
      learn_req.wdata.last_accessed = status.curr_time;  // time stamp at grant
      learn_req.wdata.port          = lrn_port;
      learn_req.wdata.mac           = lrn_mac;
   end

   always_ff @(posedge pclk26 or negedge n_p_reset26)
   begin
      if (!n_p_reset26)
         rd_wait <= 1'b0;
      else
         rd_wait <= learn_rd & learn_gnt;                // rdata registered in table
   end

   // write learn ends on grant, read learn one cycle after
   assign pready = acc & (is_learn ? (pwrite ? learn_gnt : rd_wait) : 1'b1);

   // --------------------
   // read data mux
   always_comb
   begin
      case (paddr)
         reg_div    : prdata = {24'd0, div_q};
         reg_age    : prdata = age_q;
         reg_status : prdata = {30'd0, status.inval_in_prog, status.age_check_active};
         reg_time   : prdata = status.curr_time;
         reg_inv_lo : prdata = status.lst_inv_mac[31:0];
         reg_inv_hi : prdata = {14'd0, status.lst_inv_port, status.lst_inv_mac[47:32]};
         reg_mac_lo : prdata = lrn_mac[31:0];
         reg_mac_hi : prdata = {14'd0, lrn_port, lrn_mac[47:32]};
         reg_learn  : prdata = {31'd0, rdata.valid};     // valid bit of looked-up entry
         default    : prdata = 32'd0;                    // reg_cmd reads back zero
      endcase
   end

endmodule

// ==== source/alut_mem.sv ====
// ALUT entry table
// 2**addr_w entries, one access per cycle
// fixed priority arbiter, age port first, learn port second
// registered read data shared by both requesters

module alut_mem
#(
   parameter int unsigned addr_w = 8     // table address width, up to 8
)
(
   input  logic                  pclk26,
   input  alut_pkg::mem_req_t    age_req,
   input  alut_pkg::mem_req_t    learn_req,
   output logic                  learn_gnt,
   output alut_pkg::alut_entry_t rdata
);

   import alut_pkg::*;

   localparam int unsigned depth = 1 << addr_w;

   alut_entry_t table_q [depth];         // cleared only by invalidate all
   mem_req_t    sel;                     // winning request

   // --------------------
   // arbitration
   assign learn_gnt = learn_req.req & ~age_req.req;   // age sweep always wins

   always_comb
   begin
      if (age_req.req)
         sel = age_req;
      else
         sel = learn_req;
   end

   // --------------------
   // table access
   // a write updates the entry, a read loads rdata for the next cycle
   always_ff @(posedge pclk26)
   begin
      if (sel.req)
      begin
         if (sel.write)
            table_q[sel.addr[addr_w-1:0]] <= sel.wdata;
         else
            rdata <= table_q[sel.addr[addr_w-1:0]];  // holds until the next read
      end
   end

endmodule

// ==== source/alut_age_checker.sv ====
// ALUT age checker
// time base divider and wrapping current-time counter
// sweep FSM for invalidate aged and invalidate all
// age compare, last invalidated MAC/port capture, status flags

module alut_age_checker
#(
   parameter int unsigned addr_w = 8     // table address width, up to 8
)
(
   input  logic                   pclk26,
   input  logic                   n_p_reset26,
   input  alut_pkg::alut_cfg_t    cfg,
   input  alut_pkg::age_cmd_e     cmd,
   input  alut_pkg::alut_entry_t  rdata,
   output alut_pkg::mem_req_t     age_req,
   output alut_pkg::alut_status_t status
);

   import alut_pkg::*;

   localparam logic [addr_w-1:0] addr_max = {addr_w{1'b1}};
   localparam logic [addr_w-1:0] addr_one = {{(addr_w-1){1'b0}}, 1'b1};

   age_state_e        state;
   age_state_e        nxt_state;
   logic [7:0]        clk_div_cnt;
   logic [31:0]       curr_time;
   logic [addr_w-1:0] sweep_addr;    // address under test or being cleared
   logic              last_addr;
   logic              cmp_rdy;       // second age check cycle, aged is valid
   logic              aged;          // entry valid and out of date
   logic [31:0]       elapsed;
   logic              in_date;
   logic              sweep_end;
   logic              inval_in_prog;
   logic [47:0]       lst_inv_mac;
   logic [1:0]        lst_inv_port;

   // --------------------
   // time base
   always_ff @(posedge pclk26 or negedge n_p_reset26)
   begin
      if (!n_p_reset26)
      begin
         clk_div_cnt <= 8'd0;
         curr_time   <= 32'd0;
      end
      else if (clk_div_cnt == cfg.div_clk)
      begin
         clk_div_cnt <= 8'd0;
         curr_time   <= curr_time + 32'd1;          // wraps at 2**32
      end
      else
         clk_div_cnt <= clk_div_cnt + 8'd1;
   end

   // --------------------
   // age compare, modulo 2**32 so counter wrap is harmless
   assign elapsed = curr_time - rdata.last_accessed;
   assign in_date = (cfg.best_bfr_age > elapsed);

   // first check cycle registers the result, second one acts on it
   always_ff @(posedge pclk26 or negedge n_p_reset26)
   begin
      if (!n_p_reset26)
      begin
         cmp_rdy <= 1'b0;
         aged    <= 1'b0;
      end
      else if ((state == st_age_chk) && !cmp_rdy)
      begin
         cmp_rdy <= 1'b1;
         aged    <= rdata.valid & ~in_date;
      end
      else
      begin
         cmp_rdy <= 1'b0;
         aged    <= 1'b0;
      end
   end

   // --------------------
   // sweep FSM
   assign last_addr = (sweep_addr == addr_max);

   always_comb
   begin
      nxt_state = state;
      case (state)
         st_idle :
            if (cmd == cmd_inval_aged)
               nxt_state = st_aged_rd;
            else if (cmd == cmd_inval_all)
               nxt_state = st_inval_all;           // none and reserved are ignored
         st_aged_rd :
            nxt_state = st_age_chk;
         st_age_chk :
            if (cmp_rdy)
            begin
               if (aged)
                  nxt_state = st_aged_wr;          // clear this entry first
               else if (last_addr)
                  nxt_state = st_idle;
               else
                  nxt_state = st_aged_rd;
            end
         st_aged_wr :
            nxt_state = last_addr ? st_idle : st_aged_rd;
         st_inval_all :
            if (last_addr)
               nxt_state = st_idle;
         default :
            nxt_state = st_idle;
      endcase
   end

   always_ff @(posedge pclk26 or negedge n_p_reset26)
   begin
      if (!n_p_reset26)
         state <= st_idle;
      else
         state <= nxt_state;
   end

   // step to the next address once this one is done with
   always_ff @(posedge pclk26 or negedge n_p_reset26)
   begin
      if (!n_p_reset26)
         sweep_addr <= '0;
      else if (state == st_idle)
         sweep_addr <= '0;                          // every sweep starts at 0
      else if ((state == st_inval_all) || (state == st_aged_wr) ||
               ((state == st_age_chk) && cmp_rdy && !aged))
         sweep_addr <= sweep_addr + addr_one;
   end

   // request held for the whole sweep so learn traffic stalls
   // check cycles re-read the same address, keeping rdata on that entry
   always_comb
   begin
      age_req                  = '0;               // zero write data
      age_req.req              = (state != st_idle);
      age_req.write            = (state == st_aged_wr) || (state == st_inval_all);
      age_req.addr[addr_w-1:0] = sweep_addr;
   end

   // --------------------
   // status
   assign sweep_end = (state != st_idle) && (nxt_state == st_idle);

   always_ff @(posedge pclk26 or negedge n_p_reset26)
   begin
      if (!n_p_reset26)
      begin
         inval_in_prog <= 1'b0;
         lst_inv_mac   <= 48'd0;
         lst_inv_port  <= 2'd0;
      end
      else
      begin
         if (sweep_end)
            inval_in_prog <= 1'b0;
         else if (state == st_aged_wr)
            inval_in_prog <= 1'b1;                  // first aged write sets it
         if (state == st_aged_wr)
         begin
            lst_inv_mac  <= rdata.mac;              // entry still on rdata
            lst_inv_port <= rdata.port;
         end
      end
   end

   assign status.age_check_active = (state != st_idle);
   assign status.inval_in_prog    = inval_in_prog;
   assign status.lst_inv_mac      = lst_inv_mac;
   assign status.lst_inv_port     = lst_inv_port;
   assign status.curr_time        = curr_time;

endmodule

// ==== source/alut_top.sv ====
// ALUT top level
// APB register block, entry table and age checker
// sets the table address width for the table and the checker

module alut_top
#(
   parameter int unsigned addr_w = 8     // table address width
)
(
   input  logic        pclk26,
   input  logic        n_p_reset26,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [7:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready
);

   import alut_pkg::*;

   alut_cfg_t    cfg;          // divider and best-before age
   age_cmd_e     cmd;          // command pulse
   mem_req_t     learn_req;    // registers -> table
   mem_req_t     age_req;      // checker -> table, has priority
   logic         learn_gnt;
   alut_entry_t  rdata;        // shared read data
   alut_status_t status;       // checker -> registers

   // --------------------
   // producer, APB side
   alut_apb_regs u_regs
   (
      .pclk26      (pclk26),
      .n_p_reset26 (n_p_reset26),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .learn_gnt   (learn_gnt),
      .rdata       (rdata),
      .status      (status),
      .prdata      (prdata),
      .pready      (pready),
      .cfg         (cfg),
      .cmd         (cmd),
      .learn_req   (learn_req)
   );

   // --------------------
   // entry table
   alut_mem #(.addr_w(addr_w)) u_mem
   (
      .pclk26    (pclk26),
      .age_req   (age_req),
      .learn_req (learn_req),
      .learn_gnt (learn_gnt),
      .rdata     (rdata)
   );

   // --------------------
   // consumer, ageing sweeps
   alut_age_checker #(.addr_w(addr_w)) u_age
   (
      .pclk26      (pclk26),
      .n_p_reset26 (n_p_reset26),
      .cfg         (cfg),
      .cmd         (cmd),
      .rdata       (rdata),
      .age_req     (age_req),
      .status      (status)
   );

endmodule

// ==== dv/alut_clk_gen.sv ====
// testbench clock and reset generator
// pclk26 with a period of 4, n_p_reset26 low for the first 3 cycles

module alut_clk_gen
(
   output logic pclk26,
   output logic n_p_reset26
);

   initial
   begin
      pclk26 = 1'b0;
      forever #2 pclk26 = ~pclk26;         // 4 time units per cycle
   end

   initial
   begin
      n_p_reset26 = 1'b0;                  // in reset from time 0
      repeat (3) @(posedge pclk26);
      @(negedge pclk26);
      n_p_reset26 = 1'b1;                  // release away from the rising edge
   end

endmodule

// ==== dv/alut_checker.sv ====
// testbench read checker and result counters
// compares each completed APB read with the posted expected range
// flags a learn write that completes while a sweep is active
// flags a plain register access that does not complete at once
// prints one line per test

module alut_checker
(
   input  logic                   pclk26,
   input  logic                   n_p_reset26,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [7:0]             paddr,
   input  logic [31:0]            prdata,
   input  logic                   pready,
   input  alut_pkg::alut_status_t status,
   input  logic [127:0]           test_name,   // ascii name posted by the testbench
   input  logic                   chk_en,      // compare the next completed read
   input  logic [31:0]            exp_mask,
   input  logic [31:0]            exp_lo,
   input  logic [31:0]            exp_hi,
   input  logic                   test_end,    // one cycle pulse closes a test
   output int                     n_tests,
   output int                     n_failed,
   output int                     n_checks,
   output int                     n_errors
);

   import alut_pkg::*;

   logic        done;          // access phase completes this cycle
   logic [31:0] got;
   int          test_errs;
   int          test_checks;

   assign done = psel & penable & pready;
   assign got  = prdata & exp_mask;

   always @(posedge pclk26 or negedge n_p_reset26)
   begin
      if (!n_p_reset26)
      begin
         n_tests     = 0;
         n_failed    = 0;
         n_checks    = 0;
         n_errors    = 0;
         test_errs   = 0;
         test_checks = 0;
      end
      else
      begin
         // --------------------
         // read data compare
         if (done && !pwrite && chk_en)
         begin
            n_checks    = n_checks + 1;
            test_checks = test_checks + 1;
            if ((got < exp_lo) || (got > exp_hi))
            begin
               n_errors  = n_errors + 1;
               test_errs = test_errs + 1;
               if (exp_lo == exp_hi)
                  $display("ERROR %0s: addr 0x%02h expected 0x%08h actual 0x%08h",
                           test_name, paddr, exp_lo, got);
               else
                  $display("ERROR %0s: addr 0x%02h expected 0x%08h..0x%08h actual 0x%08h",
                           test_name, paddr, exp_lo, exp_hi, got);
            end
         end
         // a learn is granted only when the age port is idle
         if (done && pwrite && (paddr == reg_learn) && status.age_check_active)
         begin
            n_errors  = n_errors + 1;
            test_errs = test_errs + 1;
            $display("%0s: a learn write completed while a sweep was still active",
                     test_name);
         end
         // plain registers complete in their first access cycle
         if (psel && penable && !pready && (paddr != reg_learn))
         begin
            n_errors  = n_errors + 1;
            test_errs = test_errs + 1;
            $display("%0s: access to 0x%02h did not complete in its first access cycle",
                     test_name, paddr);
         end
         // --------------------
         // per test result line
         if (test_end)
         begin
            n_tests = n_tests + 1;
            if (test_errs == 0)
               $display("%0s: pass, %0d checks", test_name, test_checks);
            else
            begin
               n_failed = n_failed + 1;
               $display("%0s: FAIL, %0d errors in %0d checks", test_name, test_errs,
                        test_checks);
            end
            test_errs   = 0;
            test_checks = 0;
         end
      end
   end

endmodule

// ==== dv/alut_tb.sv ====
// ALUT testbench top
// APB driver tasks, LFSR stimulus, shadow table reference model
// tests for reset, invalidate all, invalidate aged, time base and learn stall
// cycle counter timeout

module alut_tb;

   import alut_pkg::*;

   localparam int addr_w    = 8;
   localparam int depth     = 1 << addr_w;
   localparam int n_learn   = 16;          // entries learned in the aged tests
   localparam int n_sweeps  = 7;
   localparam int apb_ops   = 260;         // rough transfer count at 4 cycles each
   localparam int time_gap  = 60;          // idle cycles between the time reads
   localparam int div_val   = 3;
   localparam int cyc_limit = 2 * (n_sweeps * 4 * depth + apb_ops * 4 + time_gap);

   logic         pclk26;
   logic         n_p_reset26;
   logic         psel;
   logic         penable;
   logic         pwrite;
   logic [7:0]   paddr;
   logic [31:0]  pwdata;
   logic [31:0]  prdata;
   logic         pready;
   logic [127:0] test_name;
   logic         chk_en;
   logic [31:0]  exp_mask;
   logic [31:0]  exp_lo;
   logic [31:0]  exp_hi;
   logic         test_end;
   int           n_tests;
   int           n_failed;
   int           n_checks;
   int           n_errors;
   int           cyc = 0;
   logic [31:0]  lfsr;

   // --------------------
   // reference model state
   logic         sh_valid [depth];       // shadow table
   logic [47:0]  sh_mac   [depth];
   logic [1:0]   sh_port  [depth];
   logic [31:0]  sh_time  [depth];       // reg_time read back after the learn
   logic [7:0]   m_div;
   logic [31:0]  m_age;
   logic [47:0]  m_mac;                  // learn registers
   logic [1:0]   m_port;
   int           m_idx;                  // index of the last learn
   logic         m_active;
   logic [47:0]  m_inv_mac;
   logic [1:0]   m_inv_port;

   alut_clk_gen u_clk (.pclk26(pclk26), .n_p_reset26(n_p_reset26));

   alut_top #(.addr_w(addr_w)) dut
   (
      .pclk26      (pclk26),
      .n_p_reset26 (n_p_reset26),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready)
   );

   alut_checker u_chk
   (
      .pclk26      (pclk26),
      .n_p_reset26 (n_p_reset26),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .prdata      (prdata),
      .pready      (pready),
      .status      (dut.status),
      .test_name   (test_name),
      .chk_en      (chk_en),
      .exp_mask    (exp_mask),
      .exp_lo      (exp_lo),
      .exp_hi      (exp_hi),
      .test_end    (test_end),
      .n_tests     (n_tests),
      .n_failed    (n_failed),
      .n_checks    (n_checks),
      .n_errors    (n_errors)
   );

   // galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] galois_step(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      return s >> 1;
   endfunction

   task automatic take_bits(input int n, output logic [47:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[46:0], lfsr[0]};      // one step per bit taken
         lfsr = galois_step(lfsr);
      end
   endtask

   // expected read value from the model
   function automatic logic [31:0] ref_read(input logic [7:0] addr);
      case (addr)
         reg_div    : return {24'd0, m_div};
         reg_age    : return m_age;
         reg_status : return {31'd0, m_active};
         reg_inv_lo : return m_inv_mac[31:0];
         reg_inv_hi : return {14'd0, m_inv_port, m_inv_mac[47:32]};
         reg_mac_lo : return m_mac[31:0];
         reg_mac_hi : return {14'd0, m_port, m_mac[47:32]};
         reg_learn  : return {31'd0, sh_valid[m_idx]};
         default    : return 32'd0;
      endcase
   endfunction

   task automatic model_inval_all();
      for (int i = 0; i < depth; i++)
         sh_valid[i] = 1'b0;
   endtask

   // in date while the age is strictly above the elapsed time
   task automatic model_inval_aged(input logic [31:0] t_now);
      for (int i = 0; i < depth; i++)
      begin
         if (sh_valid[i] && !(m_age > (t_now - sh_time[i])))
         begin
            sh_valid[i] = 1'b0;
            m_inv_mac   = sh_mac[i];     // last one swept wins
            m_inv_port  = sh_port[i];
         end
      end
   endtask

   // --------------------
   // APB driver with inputs changing on the falling edge
   task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
      @(negedge pclk26);
      psel    = 1'b1;                    // setup phase
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge pclk26);
      penable = 1'b1;                    // access phase
      @(posedge pclk26);
      while (!pready)
         @(posedge pclk26);              // learn traffic may stall here
      rdata = prdata;
      @(negedge pclk26);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      logic [31:0] unused_rd;
      apb_xfer(1'b1, addr, data, unused_rd);
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      apb_xfer(1'b0, addr, 32'd0, data);
   endtask

   task automatic check_read(input logic [7:0] addr, input logic [31:0] mask,
                             input logic [31:0] lo, input logic [31:0] hi,
                             output logic [31:0] data);
      chk_en   = 1'b1;                   // posted for the checker
      exp_mask = mask;
      exp_lo   = lo;
      exp_hi   = hi;
      apb_read(addr, data);
      chk_en   = 1'b0;
   endtask

   task automatic check_exact(input logic [7:0] addr);
      logic [31:0] d;
      check_read(addr, 32'hffff_ffff, ref_read(addr), ref_read(addr), d);
   endtask

   task automatic end_test();
      @(negedge pclk26);
      test_end = 1'b1;
      @(negedge pclk26);
      test_end = 1'b0;
   endtask

   // random MAC and port into the learn registers and a random index out
   task automatic pick_entry(output int idx);
      logic [47:0] v;
      take_bits(8, v);
      idx = int'(v[7:0]);
      take_bits(2, v);
      m_port = v[1:0];
      take_bits(48, v);
      m_mac = v;
      apb_write(reg_mac_lo, m_mac[31:0]);
      apb_write(reg_mac_hi, {14'd0, m_port, m_mac[47:32]});
   endtask

   task automatic commit_learn(input int idx);
      logic [31:0] t;
      apb_write(reg_learn, 32'(idx));    // held until the table grants
      apb_read(reg_time, t);
      m_idx         = idx;
      sh_valid[idx] = 1'b1;
      sh_mac[idx]   = m_mac;
      sh_port[idx]  = m_port;
      sh_time[idx]  = t;
   endtask

   task automatic learn_random();
      int idx;
      pick_entry(idx);
      commit_learn(idx);
      check_exact(reg_learn);            // valid 1
   endtask

   // command write and active check followed by polling until idle
   task automatic run_sweep(input age_cmd_e c, input logic watch_ip);
      logic [31:0] t_now;
      logic [31:0] d;
      apb_read(reg_time, t_now);
      apb_write(reg_cmd, {30'd0, c});
      check_read(reg_status, 32'h1, ref_read(reg_status), ref_read(reg_status), d);
      d = 32'd1;
      while (d[0])
      begin
         if (watch_ip)
            check_read(reg_status, 32'h2, 32'd0, 32'd0, d);   // no aged write
         else
            apb_read(reg_status, d);
      end
      if (c == cmd_inval_all)
         model_inval_all();
      else
         model_inval_aged(t_now);
      m_active = 1'b0;
      check_exact(reg_status);
   endtask

   // --------------------
   // test sequence
   initial
   begin
      int          idx;
      logic [31:0] t0;
      logic [31:0] t1;
      logic [31:0] exp_t;

      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = 8'd0;
      pwdata     = 32'd0;
      test_name  = "startup";
      chk_en     = 1'b0;
      exp_mask   = 32'd0;
      exp_lo     = 32'd0;
      exp_hi     = 32'd0;
      test_end   = 1'b0;
      lfsr       = 32'h8bb9;
      m_div      = 8'd0;
      m_age      = 32'd0;
      m_mac      = 48'd0;
      m_port     = 2'd0;
      m_idx      = 0;                    // learn index resets to 0
      m_active   = 1'b0;
      m_inv_mac  = 48'd0;
      m_inv_port = 2'd0;
      for (int i = 0; i < depth; i++)
      begin
         sh_valid[i] = 1'b0;
         sh_mac[i]   = 48'd0;
         sh_port[i]  = 2'd0;
         sh_time[i]  = 32'd0;
      end
      wait (n_p_reset26 === 1'b1);

      test_name = "reset_inval_all";
      check_exact(reg_status);
      for (int r = 0; r < 3; r++)
      begin
         if (r > 0)
            learn_random();              // moves the read index
         m_active = 1'b1;
         run_sweep(cmd_inval_all, 1'b0);
         check_exact(reg_learn);         // valid 0
      end
      end_test();

      test_name = "aged_keep";
      m_age = 32'hffff_ffff;
      apb_write(reg_age, m_age);
      check_exact(reg_age);
      for (int k = 0; k < n_learn; k++)
         learn_random();
      m_active = 1'b1;
      run_sweep(cmd_inval_aged, 1'b1);
      check_exact(reg_learn);
      check_exact(reg_inv_lo);
      check_exact(reg_inv_hi);
      end_test();

      test_name = "aged_clear";
      m_age = 32'd0;                     // nothing is in date
      apb_write(reg_age, m_age);
      m_active = 1'b1;
      run_sweep(cmd_inval_aged, 1'b0);
      check_exact(reg_inv_lo);           // highest learned index
      check_exact(reg_inv_hi);
      check_exact(reg_learn);
      end_test();

      test_name = "time_base";
      m_div = 8'(div_val);
      apb_write(reg_div, {24'd0, m_div});
      check_exact(reg_div);
      apb_read(reg_time, t0);
      repeat (time_gap) @(posedge pclk26);
      exp_t = t0 + 32'((time_gap + 2) / (div_val + 1));   // samples are gap+2 apart
      check_read(reg_time, 32'hffff_ffff, exp_t - 32'd1, exp_t + 32'd1, t1);
      end_test();

      test_name = "learn_stall";
      pick_entry(idx);
      apb_write(reg_cmd, {30'd0, cmd_inval_all});
      model_inval_all();
      commit_learn(idx);                 // stalls behind the sweep
      check_exact(reg_status);
      check_exact(reg_learn);
      apb_write(reg_age, m_age);
      m_active = 1'b1;
      run_sweep(cmd_inval_aged, 1'b0);   // only the new entry is valid
      check_exact(reg_inv_lo);
      check_exact(reg_inv_hi);
      end_test();

      @(posedge pclk26);
      @(negedge pclk26);
      $display("tests %0d, failed %0d, checks %0d, errors %0d", n_tests, n_failed,
               n_checks, n_errors);
      if ((n_errors == 0) && (n_failed == 0) && (n_tests == 5))
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

   // --------------------
   // timeout
   always @(posedge pclk26)
   begin
      cyc <= cyc + 1;
      if (cyc >= cyc_limit)
      begin
         $display("timeout: no end of test after %0d cycles", cyc);
         $display("Test failed");
         $finish;
      end
   end

endmodule

// ==== list.f ====
source/alut_pkg.sv
source/alut_apb_regs.sv
source/alut_mem.sv
source/alut_age_checker.sv
source/alut_top.sv
dv/alut_clk_gen.sv
dv/alut_checker.sv
dv/alut_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = alut_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
